//--- Makefile
# Verilator build and run of the LPIF link testbench
TOP       ?= lpif_link_tb
SEED      ?= 89193
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_$(TOP)_$(SEED)

SOURCES := $(shell grep -v '^+' build.f)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) build.f
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR) -f build.f

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_* $(LOG)

//--- bench/lpif_link_tb.sv
/*
 * LPIF link testbench
 * Wishbone setup, PHY loopback, random flit traffic checked against a
 * queue model, lane and status checks through bring-up and shutdown
 */
module lpif_link_tb #(
  parameter int SEED = 89193
);
  timeunit 1ns;
  timeprecision 1ps;
  import lpif_link_pkg::*;

  localparam int CLK_PERIOD     = 10;
  localparam int MAX_DELAY      = 8;
  localparam int TRAFFIC_LEN    = 200;
  localparam int DRAIN_LEN      = 20;
  localparam int POLL_LIMIT     = 4 * MAX_DELAY + 8;
  localparam int TIMEOUT_CYCLES = 3 * MAX_DELAY + TRAFFIC_LEN + 3 * DRAIN_LEN + 300;
  localparam int NEVER          = 1 << 30;

  logic                     clk_wr = 1'b0;
  logic                     rst;
  logic                     wb_cyc, wb_stb, wb_we, wb_ack;
  logic [WB_ADDR_WIDTH-1:0] wb_adr;
  logic [31:0]              wb_dat_w, wb_dat_r;
  logic [3:0]               dstrm_state;
  logic [1:0]               dstrm_protid;
  logic [63:0]              dstrm_data;
  logic [7:0]               dstrm_crc;
  logic                     dstrm_dvalid, dstrm_valid;
  logic [LANE_WIDTH-1:0]    tx_phy0, tx_phy1;
  lpif_flit_t               up_flit = '0;
  // One entry per cycle, oldest first
  lpif_flit_t               sent_q[$];

  integer     seed = SEED;
  integer     traffic_seed = SEED + 1;
  int         cycle = 0;
  bit         checking = 1'b0;
  int         dx, dy, dz;
  logic       stb_u = 1'b0;
  logic [1:0] mrk_u = 2'b00;
  // Model edges, NEVER until the matching control write
  int         tx_start = NEVER, tx_stop = NEVER, rx_start = NEVER, rx_stop = NEVER;
  int         word_errors = 0, lane_errors = 0, flit_errors = 0, other_errors = 0;

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  always @(posedge clk_wr) cycle <= cycle + 1;

  // PHY loopback
  lpif_link_top lpif_link_top_inst (
    .*,
    .ustrm_state(up_flit.state),
    .ustrm_protid(up_flit.protid),
    .ustrm_data(up_flit.data),
    .ustrm_dvalid(up_flit.dvalid),
    .ustrm_crc(up_flit.crc),
    .ustrm_valid(up_flit.valid),
    .rx_phy0(tx_phy0),
    .rx_phy1(tx_phy1)
  );

  ////////////////////
  // Reference model, values as seen after edge s
  function automatic sync_state_e model_state(int s);
    if (s < tx_start || s >= tx_stop) return SYNC_IDLE;
    if (s < tx_start + dz) return SYNC_ALIGN;
    if (s < tx_start + dz + dx) return SYNC_WAIT;
    return SYNC_ONLINE;
  endfunction

  function automatic logic rx_live(int s);
    return (s >= rx_start) && (s < rx_stop);
  endfunction

  function automatic logic [31:0] status_model(int s);
    sync_state_e st;
    st = model_state(s);
    return {28'h0, st, rx_live(s), st == SYNC_ONLINE};
  endfunction

  function automatic logic [LANE_WIDTH-1:0] expected_lane(int lane, sync_state_e st,
                                                        logic [FLIT_WIDTH-1:0] bits);
    logic stb;
    logic mrk;
    stb = (st == SYNC_ALIGN) || (st == SYNC_ONLINE && stb_u);
    mrk = (st == SYNC_ALIGN) || (st == SYNC_ONLINE && mrk_u[lane]);
    if (st != SYNC_ONLINE) return {mrk, stb, {LANE_PAYLOAD{1'b0}}};
    return {mrk, stb, bits[lane*LANE_PAYLOAD +: LANE_PAYLOAD]};
  endfunction

  ////////////////////
  // Compare tasks
  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      word_errors++;
    end
  endtask

  task automatic check_lane(input string name, input logic [LANE_WIDTH-1:0] exp,
                            input logic [LANE_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("** Error %s at cycle %0d: expected %h, actual %h", name, cycle, exp, act);
      lane_errors++;
    end
  endtask

  task automatic check_flit(input string name, input lpif_flit_t exp, input lpif_flit_t act);
    if (act !== exp) begin
      $display("** Error %s at cycle %0d: expected %h, actual %h", name, cycle, exp, act);
      flit_errors++;
    end
  endtask

  ////////////////////
  // Wishbone master, returns the ack edge
  task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr, input logic [31:0] dat,
                          output int ack_edge);
    @(negedge clk_wr);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge clk_wr);
    while (!wb_ack) @(negedge clk_wr);
    ack_edge = cycle;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
  endtask

  task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr, output logic [31:0] dat,
                         output int ack_edge);
    @(negedge clk_wr);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk_wr);
    while (!wb_ack) @(negedge clk_wr);
    dat      = wb_dat_r;
    ack_edge = cycle;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
  endtask

  task automatic reg_roundtrip(input logic [WB_ADDR_WIDTH-1:0] adr, input logic [31:0] value,
                               input logic [31:0] mask, input string name);
    int          e;
    logic [31:0] rd;
    wb_write(adr, value, e);
    wb_read(adr, rd, e);
    check_word(name, value & mask, rd);
  endtask

  // Status polled until the online bits match, every read checked
  task automatic poll_online(input logic [1:0] want);
    int          e;
    int          polls;
    logic [31:0] rd;
    polls = 0;
    do begin
      // Read data reflects the edge before the ack
      wb_read(REG_STATUS, rd, e);
      check_word("status during bring-up", status_model(e - 1), rd);
      polls++;
    end while (rd[1:0] != want && polls < POLL_LIMIT);
    if (rd[1:0] != want) begin
      $display("Status never showed online bits %b", want);
      other_errors++;
    end
  endtask

  ////////////////////
  // Traffic and per-cycle checks
  always @(negedge clk_wr) begin : traffic_monitor
    lpif_flit_t  oldest;
    lpif_flit_t  expect_down;
    logic [95:0] rnd;
    sync_state_e st;
    oldest = '0;
    if (sent_q.size() == 4) oldest = sent_q.pop_front();
    if (checking) begin
      // Lanes lag the state by one edge, payload is two cycles old
      st = model_state(cycle - 1);
      check_lane("tx lane 0", expected_lane(0, st, sent_q[1]), tx_phy0);
      check_lane("tx lane 1", expected_lane(1, st, sent_q[1]), tx_phy1);
      expect_down = (model_state(cycle - 3) == SYNC_ONLINE) ? oldest : '0;
      expect_down.valid  = expect_down.valid & rx_live(cycle);
      expect_down.dvalid = expect_down.dvalid & rx_live(cycle);
      check_flit("downstream flit", expect_down,
                 {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid, dstrm_crc, dstrm_valid});
      rnd = {$random(traffic_seed), $random(traffic_seed), $random(traffic_seed)};
      up_flit = rnd[FLIT_WIDTH-1:0];
    end else begin
      up_flit = '0;
    end
    sent_q.push_back(up_flit);
  end

  initial begin : main_sequence
    int          e;
    logic [31:0] rd;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (8) @(negedge clk_wr);
    rst = 1'b0;
    repeat (2) @(negedge clk_wr);
    checking = 1'b1;

    wb_read(REG_STATUS, rd, e);
    check_word("status after reset", 32'h0, rd);
    reg_roundtrip(REG_DELAY_X, $random(seed), 32'hFFFF, "delay_x readback");
    reg_roundtrip(REG_DELAY_Y, $random(seed), 32'hFFFF, "delay_y readback");
    reg_roundtrip(REG_DELAY_Z, $random(seed), 32'hFFFF, "delay_z readback");
    // Online bits kept clear so the link stays idle
    reg_roundtrip(REG_CTRL, $random(seed) & ~32'h3, 32'h1F, "ctrl readback");

    ////////////////////
    // Bring-up with small delays
    dx = 1 + ($random(seed) & (MAX_DELAY - 1));
    dy = 1 + ($random(seed) & (MAX_DELAY - 1));
    dz = 1 + ($random(seed) & (MAX_DELAY - 1));
    rd = $random(seed);
    stb_u = rd[4];
    mrk_u = rd[3:2];
    wb_write(REG_DELAY_X, dx, e);
    wb_write(REG_DELAY_Y, dy, e);
    wb_write(REG_DELAY_Z, dz, e);
    wb_write(REG_CTRL, {27'h0, stb_u, mrk_u, 2'b01}, e);
    tx_start = e + 1;
    poll_online(2'b01);
    // Live traffic reaches the receive side while it is still offline
    repeat (DRAIN_LEN) @(negedge clk_wr);
    wb_write(REG_CTRL, {27'h0, stb_u, mrk_u, 2'b11}, e);
    rx_start = e + 1 + dy;
    poll_online(2'b11);

    repeat (TRAFFIC_LEN) @(negedge clk_wr);
    wb_write(REG_CTRL, {27'h0, stb_u, mrk_u, 2'b01}, e);
    rx_stop = e + 1;
    repeat (DRAIN_LEN) @(negedge clk_wr);
    wb_write(REG_CTRL, {27'h0, stb_u, mrk_u, 2'b00}, e);
    tx_stop = e + 1;
    repeat (DRAIN_LEN) @(negedge clk_wr);
    wb_read(REG_STATUS, rd, e);
    check_word("status after shutdown", status_model(e - 1), rd);
    checking = 1'b0;

    $display("Error counts: register %0d, lane %0d, flit %0d, other %0d",
             word_errors, lane_errors, flit_errors, other_errors);
    if (word_errors + lane_errors + flit_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- build.f
verilog/lpif_link_pkg.sv
verilog/link_cfg_regs.sv
verilog/delay_timer.sv
verilog/link_sync_fsm.sv
verilog/lpif_flit_pack.sv
verilog/lane_stripe.sv
verilog/lpif_link_top.sv
bench/lpif_link_tb.sv

//--- verilog/delay_timer.sv
/*
 * Delay timer
 * Loadable down-counter that flags when a programmed number of
 * cycles has passed
 */
module delay_timer (
  input  logic                                   clk_wr,
  input  logic                                   rst,
  input  logic                                   load,
  input  logic [lpif_link_pkg::DELAY_WIDTH-1:0]  load_value,
  output logic                                   done
);
  import lpif_link_pkg::*;

  logic [DELAY_WIDTH-1:0] count;

  // Count is held one below the load value, so done is seen at the
  // V-th edge after the load; zero behaves like one
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      if (load_value == '0) begin
        count <= '0;
      end else begin
        count <= load_value - 1'b1;
      end
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Sticks high until the next load
  assign done = (count == '0);

endmodule

//--- verilog/lane_stripe.sv
/*
 * Lane striper
 * Splits the transmit flit over the PHY lanes with strobe and marker,
 * and rebuilds the received flit from the lane payloads
 */
module lane_stripe (
  input  logic                                  clk_wr,
  input  logic                                  rst,
  input  lpif_link_pkg::lpif_flit_t             tx_flit,
  input  logic                                  tx_online_delay,
  input  logic                                  auto_stb,
  input  logic [1:0]                            auto_mrk,
  input  logic [lpif_link_pkg::LANE_WIDTH-1:0]  rx_phy0,
  input  logic [lpif_link_pkg::LANE_WIDTH-1:0]  rx_phy1,
  output logic [lpif_link_pkg::LANE_WIDTH-1:0]  tx_phy0,
  output logic [lpif_link_pkg::LANE_WIDTH-1:0]  tx_phy1,
  output lpif_link_pkg::lpif_flit_t             rx_flit
);
  import lpif_link_pkg::*;

  logic [FLIT_WIDTH-1:0] tx_bits;
  logic [FLIT_WIDTH-1:0] rx_bits;
  logic [LANE_WIDTH-1:0] tx_lane [LANE_COUNT];
  logic [LANE_WIDTH-1:0] rx_lane [LANE_COUNT];

  assign tx_bits    = tx_flit;
  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;

  ////////////////////
  // Transmit lanes
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      if (rst) begin
        tx_lane[i] <= '0;
      end else begin
        // Payload held at zero until the link is live
        if (tx_online_delay) begin
          tx_lane[i][LANE_PAYLOAD-1:0] <= tx_bits[i*LANE_PAYLOAD +: LANE_PAYLOAD];
        end else begin
          tx_lane[i][LANE_PAYLOAD-1:0] <= '0;
        end
        tx_lane[i][LANE_PAYLOAD]   <= auto_stb;
        tx_lane[i][LANE_PAYLOAD+1] <= auto_mrk[i];
      end
    end
  end

  assign tx_phy0 = tx_lane[0];
  assign tx_phy1 = tx_lane[1];

  ////////////////////
  // Receive reassembly, strobe and marker dropped
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      rx_bits[i*LANE_PAYLOAD +: LANE_PAYLOAD] <= rx_lane[i][LANE_PAYLOAD-1:0];
    end
  end

  assign rx_flit = lpif_flit_t'(rx_bits);

  // Offline sequencer keeps both lanes quiet one edge later
  assert property (@(posedge clk_wr) disable iff (rst)
    !tx_online_delay |=> (tx_phy0[LANE_PAYLOAD-1:0] == '0) &&
                         (tx_phy1[LANE_PAYLOAD-1:0] == '0));

endmodule

//--- verilog/link_cfg_regs.sv
/*
 * Link configuration registers
 * Wishbone classic slave for delays, user bits and online requests,
 * plus a read-only status word
 */
module link_cfg_regs (
  input  logic                                     clk_wr,
  input  logic                                     rst,
  input  logic                                     wb_cyc,
  input  logic                                     wb_stb,
  input  logic                                     wb_we,
  input  logic [lpif_link_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
  input  logic [31:0]                              wb_dat_w,
  output logic                                     wb_ack,
  output logic [31:0]                              wb_dat_r,
  output logic [lpif_link_pkg::DELAY_WIDTH-1:0]    delay_x,
  output logic [lpif_link_pkg::DELAY_WIDTH-1:0]    delay_y,
  output logic [lpif_link_pkg::DELAY_WIDTH-1:0]    delay_z,
  output logic                                     tx_online,
  output logic                                     rx_online,
  output logic [1:0]                               mrk_userbit,
  output logic                                     stb_userbit,
  input  logic                                     tx_online_delay,
  input  logic                                     rx_online_delay,
  input  lpif_link_pkg::sync_state_e               sync_state
);
  import lpif_link_pkg::*;

  localparam int PAD = 32 - DELAY_WIDTH;

  logic        access;
  logic [31:0] read_word;

  // New cycle seen at this edge
  assign access = wb_cyc && wb_stb && !wb_ack;

  always_comb begin
    case (wb_adr)
      REG_DELAY_X: read_word = {{PAD{1'b0}}, delay_x};
      REG_DELAY_Y: read_word = {{PAD{1'b0}}, delay_y};
      REG_DELAY_Z: read_word = {{PAD{1'b0}}, delay_z};
      REG_CTRL:    read_word = {27'h0, stb_userbit, mrk_userbit, rx_online, tx_online};
      REG_STATUS:  read_word = {28'h0, sync_state, rx_online_delay, tx_online_delay};
      default:     read_word = '0;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  // Read data held for the ack cycle
  always_ff @(posedge clk_wr) begin
    if (access) begin
      wb_dat_r <= read_word;
    end
  end

  ////////////////////
  // Register writes, status and unused words ignored
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      delay_x     <= '0;
      delay_y     <= '0;
      delay_z     <= '0;
      tx_online   <= 1'b0;
      rx_online   <= 1'b0;
      mrk_userbit <= '0;
      stb_userbit <= 1'b0;
    end else if (access && wb_we) begin
      case (wb_adr)
        REG_DELAY_X: delay_x <= wb_dat_w[DELAY_WIDTH-1:0];
        REG_DELAY_Y: delay_y <= wb_dat_w[DELAY_WIDTH-1:0];
        REG_DELAY_Z: delay_z <= wb_dat_w[DELAY_WIDTH-1:0];
        REG_CTRL: begin
          tx_online   <= wb_dat_w[0];
          rx_online   <= wb_dat_w[1];
          mrk_userbit <= wb_dat_w[3:2];
          stb_userbit <= wb_dat_w[4];
        end
        default: ;
      endcase
    end
  end

  // Classic handshake, one ack per transfer
  assert property (@(posedge clk_wr) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

//--- verilog/link_sync_fsm.sv
/*
 * Link bring-up sequencer
 * Delays the online requests, drives the alignment strobe and marker,
 * and loads the two delay timers
 */
module link_sync_fsm (
  input  logic                                   clk_wr,
  input  logic                                   rst,
  input  logic                                   tx_online,
  input  logic                                   rx_online,
  input  logic [lpif_link_pkg::DELAY_WIDTH-1:0]  delay_x,
  input  logic [lpif_link_pkg::DELAY_WIDTH-1:0]  delay_y,
  input  logic [lpif_link_pkg::DELAY_WIDTH-1:0]  delay_z,
  input  logic [1:0]                             mrk_userbit,
  input  logic                                   stb_userbit,
  input  logic                                   tx_done,
  input  logic                                   rx_done,
  output logic                                   tx_load,
  output logic [lpif_link_pkg::DELAY_WIDTH-1:0]  tx_load_value,
  output logic                                   rx_load,
  output logic [lpif_link_pkg::DELAY_WIDTH-1:0]  rx_load_value,
  output logic                                   tx_online_delay,
  output logic                                   rx_online_delay,
  output logic                                   auto_stb,
  output logic [1:0]                             auto_mrk,
  output lpif_link_pkg::sync_state_e             sync_state
);
  import lpif_link_pkg::*;

  sync_state_e state_q;
  sync_state_e state_d;
  logic        rx_armed;

  ////////////////////
  // Transmit sequence
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      state_q <= SYNC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    tx_load = 1'b0;
    if (!tx_online) begin
      state_d = SYNC_IDLE;
    end else begin
      case (state_q)
        SYNC_IDLE: begin
          state_d = SYNC_ALIGN;
          tx_load = 1'b1;
        end
        SYNC_ALIGN: if (tx_done) begin
          state_d = SYNC_WAIT;
          tx_load = 1'b1;
        end
        SYNC_WAIT: if (tx_done) state_d = SYNC_ONLINE;
        default: state_d = SYNC_ONLINE;
      endcase
    end
  end

  // Alignment length first, then the settle time
  assign tx_load_value   = (state_q == SYNC_IDLE) ? delay_z : delay_x;
  assign tx_online_delay = (state_q == SYNC_ONLINE);
  assign sync_state      = state_q;

  // Persistent pattern while aligning, user bits once live
  always_comb begin
    case (state_q)
      SYNC_ALIGN: begin
        auto_stb = 1'b1;
        auto_mrk = 2'b11;
      end
      SYNC_ONLINE: begin
        auto_stb = stb_userbit;
        auto_mrk = mrk_userbit;
      end
      default: begin
        auto_stb = 1'b0;
        auto_mrk = 2'b00;
      end
    endcase
  end

  ////////////////////
  // Receive side
  assign rx_load       = rx_online && !rx_armed;
  assign rx_load_value = delay_y;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_armed        <= 1'b0;
      rx_online_delay <= 1'b0;
    end else begin
      rx_armed        <= rx_online;
      rx_online_delay <= rx_online && (rx_online_delay || (rx_armed && rx_done));
    end
  end

  // Delayed flag lags the request by at most one edge on the way down
  assert property (@(posedge clk_wr) disable iff (rst)
    tx_online_delay |-> $past(tx_online));

endmodule

//--- verilog/lpif_flit_pack.sv
/*
 * Flit packer
 * Registers upstream fields into a flit, and received flits onto the
 * downstream channel with the valid bits gated by receive online
 */
module lpif_flit_pack (
  input  logic                       clk_wr,
  input  logic                       rst,
  // Upstream channel
  input  logic [3:0]                 ustrm_state,
  input  logic [1:0]                 ustrm_protid,
  input  logic [63:0]                ustrm_data,
  input  logic                       ustrm_dvalid,
  input  logic [7:0]                 ustrm_crc,
  input  logic                       ustrm_valid,
  // From the lanes
  input  lpif_link_pkg::lpif_flit_t  rx_flit,
  input  logic                       rx_online_delay,
  // Downstream channel
  output logic [3:0]                 dstrm_state,
  output logic [1:0]                 dstrm_protid,
  output logic [63:0]                dstrm_data,
  output logic                       dstrm_dvalid,
  output logic [7:0]                 dstrm_crc,
  output logic                       dstrm_valid,
  output lpif_link_pkg::lpif_flit_t  tx_flit
);
  import lpif_link_pkg::*;

  lpif_flit_t dstrm_q;

  // Upstream capture, CRC is carried through untouched
  always_ff @(posedge clk_wr) begin
    tx_flit.state  <= ustrm_state;
    tx_flit.protid <= ustrm_protid;
    tx_flit.data   <= ustrm_data;
    tx_flit.crc    <= ustrm_crc;
    if (rst) begin
      tx_flit.dvalid <= 1'b0;
      tx_flit.valid  <= 1'b0;
    end else begin
      tx_flit.dvalid <= ustrm_dvalid;
      tx_flit.valid  <= ustrm_valid;
    end
  end

  always_ff @(posedge clk_wr) begin
    dstrm_q.state  <= rx_flit.state;
    dstrm_q.protid <= rx_flit.protid;
    dstrm_q.data   <= rx_flit.data;
    dstrm_q.crc    <= rx_flit.crc;
    if (rst) begin
      dstrm_q.dvalid <= 1'b0;
      dstrm_q.valid  <= 1'b0;
    end else begin
      dstrm_q.dvalid <= rx_flit.dvalid;
      dstrm_q.valid  <= rx_flit.valid;
    end
  end

  assign dstrm_state  = dstrm_q.state;
  assign dstrm_protid = dstrm_q.protid;
  assign dstrm_data   = dstrm_q.data;
  assign dstrm_crc    = dstrm_q.crc;
  // Nothing is valid until the receive side is live
  assign dstrm_dvalid = dstrm_q.dvalid & rx_online_delay;
  assign dstrm_valid  = dstrm_q.valid & rx_online_delay;

endmodule

//--- verilog/lpif_link_pkg.sv
/*
 * LPIF link shared definitions
 * Lane and flit geometry, flit field layout, bring-up states and
 * the Wishbone register map
 */
package lpif_link_pkg;

  ////////////////////
  // Lane and flit geometry
  localparam int LANE_COUNT   = 2;
  localparam int LANE_PAYLOAD = 40;
  // Payload, then strobe at bit 40, marker at bit 41
  localparam int LANE_WIDTH   = LANE_PAYLOAD + 2;
  localparam int FLIT_WIDTH   = LANE_COUNT * LANE_PAYLOAD;

  localparam int DELAY_WIDTH   = 16;
  localparam int WB_ADDR_WIDTH = 3;

  // MSB first; lane 0 carries bits 39..0, lane 1 bits 79..40
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [7:0]  crc;
    logic        valid;
  } lpif_flit_t;

  // Transmit bring-up sequence
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_ALIGN,
    SYNC_WAIT,
    SYNC_ONLINE
  } sync_state_e;

  ////////////////////
  // Register word addresses
  localparam logic [WB_ADDR_WIDTH-1:0] REG_DELAY_X = 3'd0;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_DELAY_Y = 3'd1;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_DELAY_Z = 3'd2;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL    = 3'd3;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS  = 3'd4;

endpackage

//--- verilog/lpif_link_top.sv
/*
 * LPIF link slave
 * Wishbone configuration, bring-up sequencer and two-lane flit data path
 */
module lpif_link_top (
  input  logic                                     clk_wr,
  input  logic                                     rst,
  // Wishbone slave
  input  logic                                     wb_cyc,
  input  logic                                     wb_stb,
  input  logic                                     wb_we,
  input  logic [lpif_link_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
  input  logic [31:0]                              wb_dat_w,
  output logic                                     wb_ack,
  output logic [31:0]                              wb_dat_r,
  // User channel
  input  logic [3:0]                               ustrm_state,
  input  logic [1:0]                               ustrm_protid,
  input  logic [63:0]                              ustrm_data,
  input  logic                                     ustrm_dvalid,
  input  logic [7:0]                               ustrm_crc,
  input  logic                                     ustrm_valid,
  output logic [3:0]                               dstrm_state,
  output logic [1:0]                               dstrm_protid,
  output logic [63:0]                              dstrm_data,
  output logic                                     dstrm_dvalid,
  output logic [7:0]                               dstrm_crc,
  output logic                                     dstrm_valid,
  // PHY lanes
  output logic [lpif_link_pkg::LANE_WIDTH-1:0]     tx_phy0,
  output logic [lpif_link_pkg::LANE_WIDTH-1:0]     tx_phy1,
  input  logic [lpif_link_pkg::LANE_WIDTH-1:0]     rx_phy0,
  input  logic [lpif_link_pkg::LANE_WIDTH-1:0]     rx_phy1
);
  import lpif_link_pkg::*;

  logic [DELAY_WIDTH-1:0] delay_x, delay_y, delay_z;
  logic [DELAY_WIDTH-1:0] tx_load_value, rx_load_value;
  logic [1:0]             mrk_userbit, auto_mrk;
  logic                   tx_online, rx_online, stb_userbit, auto_stb;
  logic                   tx_online_delay, rx_online_delay;
  logic                   tx_load, rx_load, tx_done, rx_done;
  sync_state_e            sync_state;
  lpif_flit_t             tx_flit, rx_flit;

  // Names line up across the blocks
  link_cfg_regs link_cfg_regs_inst (.*);
  link_sync_fsm link_sync_fsm_inst (.*);

  delay_timer tx_timer_inst (
    .clk_wr(clk_wr), .rst(rst), .load(tx_load), .load_value(tx_load_value), .done(tx_done)
  );
  delay_timer rx_timer_inst (
    .clk_wr(clk_wr), .rst(rst), .load(rx_load), .load_value(rx_load_value), .done(rx_done)
  );

  lpif_flit_pack lpif_flit_pack_inst (.*);
  lane_stripe    lane_stripe_inst (.*);

endmodule
